// File: rtl/alsPkg.sv
package alsPkg;

    // Sensor array size
    localparam int ChannelCount = 4;

    // Extra idle serial clock edges between two frames
    localparam int QueryDelay = 4;

    // Serial clock shape in clk cycles
    localparam int SckLowCycles  = 8;
    // High phase count includes the strobe cycle
    localparam int SckHighCycles = 8;
    localparam int SckCntWidth   = 3;

    // Frame layout in serial clock edges
    localparam int PrefixBits  = 3;
    localparam int DataBits    = 8;
    localparam int PostfixBits = 7;

    typedef logic [DataBits-1:0] lightT;
    typedef logic [$clog2(ChannelCount)-1:0] chanIdxT;

    // Wide enough for all channels at full scale
    typedef logic [DataBits+$clog2(ChannelCount)-1:0] lightSumT;

    typedef logic [7:0] frameCntT;

    typedef enum logic [1:0] {
        SckDown,
        SckEdge,
        SckUp
    } sckStateT;

    typedef enum logic [1:0] {
        RdIdle,
        RdPrefix,
        RdData,
        RdPostfix
    } readerStateT;

endpackage

// File: rtl/sckGen.sv
`timescale 1ns/1ps

module sckGen import alsPkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic sck,
    output logic sckEdge
);

    sckStateT               state;
    sckStateT               stateNext;
    logic [SckCntWidth-1:0] cnt;
    logic [SckCntWidth-1:0] cntNext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SckDown;
            cnt   <= '0;
        end else begin
            state <= stateNext;
            cnt   <= cntNext;
        end
    end

    // Low phase, one strobe cycle, then the rest of the high phase
    always_comb begin
        stateNext = state;
        cntNext   = cnt + 1'b1;
        case (state)
            SckDown: begin
                if (cnt == SckCntWidth'(SckLowCycles - 1)) begin
                    stateNext = SckEdge;
                    cntNext   = '0;
                end
            end
            SckEdge: begin
                stateNext = SckUp;
                cntNext   = '0;
            end
            SckUp: begin
                // Strobe cycle already spent one high cycle
                if (cnt == SckCntWidth'(SckHighCycles - 2)) begin
                    stateNext = SckDown;
                    cntNext   = '0;
                end
            end
            default: begin
                stateNext = SckDown;
                cntNext   = '0;
            end
        endcase
    end

    assign sck     = (state != SckDown);
    assign sckEdge = (state == SckEdge);

endmodule

// File: rtl/alsReader.sv
`timescale 1ns/1ps

module alsReader import alsPkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sckEdge,
    input  logic  sdo,
    output logic  cs,
    output lightT light,
    output logic  lightValid
);

    readerStateT state;
    readerStateT stateNext;
    frameCntT    cnt;
    frameCntT    cntNext;
    frameCntT    stateLast;
    lightT       shiftReg;
    logic        latchNow;

    // Final counter value of the current frame section
    always_comb begin
        case (state)
            RdIdle: begin
                // One edge more than the query delay
                stateLast = frameCntT'(QueryDelay);
            end
            RdPrefix: begin
                stateLast = frameCntT'(PrefixBits - 1);
            end
            RdData: begin
                stateLast = frameCntT'(DataBits - 1);
            end
            RdPostfix: begin
                stateLast = frameCntT'(PostfixBits - 1);
            end
            default: begin
                stateLast = '0;
            end
        endcase
    end

    // Section sequencing on serial clock edges only
    always_comb begin
        stateNext = state;
        cntNext   = cnt;
        if (sckEdge) begin
            if (cnt == stateLast) begin
                cntNext = '0;
                case (state)
                    RdIdle: begin
                        stateNext = RdPrefix;
                    end
                    RdPrefix: begin
                        stateNext = RdData;
                    end
                    RdData: begin
                        stateNext = RdPostfix;
                    end
                    default: begin
                        stateNext = RdIdle;
                    end
                endcase
            end else begin
                cntNext = cnt + 1'b1;
            end
        end
    end

    // Shift register is complete at the first postfix edge
    assign latchNow = sckEdge && (state == RdPostfix) && (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RdIdle;
            cnt        <= '0;
            light      <= '0;
            lightValid <= 1'b0;
        end else begin
            state      <= stateNext;
            cnt        <= cntNext;
            lightValid <= latchNow;
            if (latchNow) begin
                light <= shiftReg;
            end
        end
    end

    // MSB arrives first
    always_ff @(posedge clk) begin
        if (sckEdge && (state == RdData)) begin
            shiftReg <= {shiftReg[DataBits-2:0], sdo};
        end
    end

    // Chip select stays asserted for the whole prefix, data and postfix
    assign cs = (state == RdIdle);

endmodule

// File: rtl/lightAggregator.sv
`timescale 1ns/1ps

module lightAggregator import alsPkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lightT                   light [ChannelCount],
    input  logic [ChannelCount-1:0] lightValid,
    output lightT                   averageLight,
    output chanIdxT                 brightest,
    output logic                    sampleValid
);

    logic [ChannelCount-1:0] fresh;
    logic [ChannelCount-1:0] freshNext;
    logic                    allFresh;
    lightSumT                lightSum;
    lightT                   maxLight;
    chanIdxT                 maxIdx;

    // Channels may report in any order and any cycle
    assign freshNext = fresh | lightValid;
    assign allFresh  = &freshNext;

    always_comb begin
        lightSum = '0;
        for (int i = 0; i < ChannelCount; i++) begin
            lightSum = lightSum + lightSumT'(light[i]);
        end
    end

    // Strict compare so a tie keeps the lower index
    always_comb begin
        maxLight = light[0];
        maxIdx   = '0;
        for (int i = 1; i < ChannelCount; i++) begin
            if (light[i] > maxLight) begin
                maxLight = light[i];
                maxIdx   = chanIdxT'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fresh        <= '0;
            sampleValid  <= 1'b0;
            averageLight <= '0;
            brightest    <= '0;
        end else begin
            sampleValid <= allFresh;
            if (allFresh) begin
                // New round starts once the result is taken
                fresh        <= '0;
                averageLight <= lightT'(lightSum / ChannelCount);
                brightest    <= maxIdx;
            end else begin
                fresh <= freshNext;
            end
        end
    end

endmodule

// File: rtl/alsArray.sv
`timescale 1ns/1ps

module alsArray import alsPkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [ChannelCount-1:0] sdo,
    output logic [ChannelCount-1:0] cs,
    output logic                    sck,
    output lightT                   channelLight [ChannelCount],
    output lightT                   averageLight,
    output chanIdxT                 brightest,
    output logic                    sampleValid
);

    logic                    sckEdge;
    logic [ChannelCount-1:0] lightValid;

    // Shared serial clock for all sensors
    sckGen i_sckGen (
        .clk     (clk),
        .rst_n   (rst_n),
        .sck     (sck),
        .sckEdge (sckEdge)
    );

    // One reader per sensor with its own chip select
    for (genvar g = 0; g < ChannelCount; g++) begin : genReader
        alsReader i_alsReader (
            .clk        (clk),
            .rst_n      (rst_n),
            .sckEdge    (sckEdge),
            .sdo        (sdo[g]),
            .cs         (cs[g]),
            .light      (channelLight[g]),
            .lightValid (lightValid[g])
        );
    end

    lightAggregator i_lightAggregator (
        .clk          (clk),
        .rst_n        (rst_n),
        .light        (channelLight),
        .lightValid   (lightValid),
        .averageLight (averageLight),
        .brightest    (brightest),
        .sampleValid  (sampleValid)
    );

endmodule

// File: sim/alsSensorModel.sv
`timescale 1ns/1ps

module alsSensorModel import alsPkg::*; (
    input  logic  clk,
    input  logic  cs,
    input  logic  sck,
    input  lightT dataByte,
    output logic  sdo
);

    // Three leading zeros, the sample MSB first, five trailing zeros
    logic [15:0] frameWord = '0;
    logic        sckPrev   = 1'b0;
    logic        armed     = 1'b0;

    // Everything is looked at on the falling clk edge
    always @(negedge clk) begin
        sckPrev <= sck;
        if (cs) begin
            // Keep the next word ready while idle
            frameWord <= {3'b000, dataByte, 5'b00000};
            armed     <= 1'b0;
        end else if (sck && !sckPrev) begin
            // The reader has taken the bit on this rising sck
            armed <= 1'b1;
        end else if (!sck && sckPrev && armed) begin
            frameWord <= {frameWord[14:0], 1'b0};
        end
    end

    assign sdo = frameWord[15];

endmodule

// File: sim/alsArrayTb.sv
`timescale 1ns/1ps

module alsArrayTb import alsPkg::*; ();

    localparam int TestCount   = 12;
    localparam int GoldenCols  = ChannelCount + 2;
    localparam int ClkPeriod   = 20;
    localparam int SckPeriod   = SckLowCycles + SckHighCycles;
    localparam int CsLowCycles = (PrefixBits + DataBits + PostfixBits) * SckPeriod;
    localparam int FrameCycles = (QueryDelay + 1) * SckPeriod + CsLowCycles;
    localparam int TimeoutNs   = TestCount * FrameCycles * ClkPeriod * 2 + 2000;

    logic                    clk;
    logic                    rst_n;
    logic [ChannelCount-1:0] sdo;
    logic [ChannelCount-1:0] cs;
    logic                    sck;
    lightT                   channelLight [ChannelCount];
    lightT                   averageLight;
    chanIdxT                 brightest;
    logic                    sampleValid;

    lightT      sensorByte [ChannelCount];
    logic [7:0] golden [TestCount*GoldenCols];
    int         errCount   = 0;
    int         testPasses = 0;
    int         testFails  = 0;

    // Frame timing monitor state
    int                      cycle;
    int                      csFallAt [ChannelCount];
    logic [ChannelCount-1:0] csPrev;
    logic                    svPrev;
    int                      svLastAt;
    int                      csPeriods;
    int                      svGaps;
    int                      timingErrs = 0;

    alsArray i_alsArray (
        .clk          (clk),
        .rst_n        (rst_n),
        .sdo          (sdo),
        .cs           (cs),
        .sck          (sck),
        .channelLight (channelLight),
        .averageLight (averageLight),
        .brightest    (brightest),
        .sampleValid  (sampleValid)
    );

    for (genvar g = 0; g < ChannelCount; g++) begin : genSensor
        alsSensorModel i_sensor (
            .clk      (clk),
            .cs       (cs[g]),
            .sck      (sck),
            .dataByte (sensorByte[g]),
            .sdo      (sdo[g])
        );
    end

    initial clk = 1'b0;
    always #(ClkPeriod/2) clk = ~clk;

    initial begin
        #(TimeoutNs);
        $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic checkLight(input string name, input lightT expected, input lightT actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %02h, actual %02h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkIndex(input string name, input chanIdxT expected, input chanIdxT actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkSelect(input string name, input logic [ChannelCount-1:0] expected,
                               input logic [ChannelCount-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected %0d clk, actual %0d clk", name, expected, actual);
            timingErrs++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            $display("test %s: ok", name);
            testPasses++;
        end else begin
            $display("test %s: %0d errors", name, errCount - errBefore);
            testFails++;
        end
    endtask

    // Everything quiet and zero
    task automatic checkIdle(input string name);
        checkSelect({name, " cs"}, '1, cs);
        checkLevel({name, " sck"}, 1'b0, sck);
        checkLevel({name, " sampleValid"}, 1'b0, sampleValid);
        for (int i = 0; i < ChannelCount; i++) begin
            checkLight($sformatf("%s channelLight[%0d]", name, i), '0, channelLight[i]);
        end
        checkLight({name, " averageLight"}, '0, averageLight);
        checkIndex({name, " brightest"}, '0, brightest);
    endtask

    // Load the sensors, watch the hold and check the result of one golden line
    task automatic runFrame(input int t);
        string   name;
        int      errBefore;
        int      base;
        logic    loaded;
        lightT   heldLight [ChannelCount];
        lightT   lastLight [ChannelCount];
        lightT   heldAvg;
        chanIdxT heldIdx;

        name      = $sformatf("golden %0d", t);
        errBefore = errCount;
        base      = t * GoldenCols;
        loaded    = 1'b0;
        heldLight = channelLight;
        lastLight = channelLight;
        heldAvg   = averageLight;
        heldIdx   = brightest;
        @(negedge clk);
        while (!sampleValid) begin
            if (!loaded && (cs == '1)) begin
                for (int i = 0; i < ChannelCount; i++) begin
                    sensorByte[i] <= golden[base+i];
                end
                loaded = 1'b1;
            end
            checkLight({name, " hold averageLight"}, heldAvg, averageLight);
            checkIndex({name, " hold brightest"}, heldIdx, brightest);
            // Samples may only move in the cycle right before sampleValid
            for (int i = 0; i < ChannelCount; i++) begin
                checkLight($sformatf("%s hold channelLight[%0d]", name, i),
                           heldLight[i], lastLight[i]);
            end
            lastLight = channelLight;
            @(negedge clk);
        end
        if (!loaded) begin
            $display("%s: result arrived before cs went high to take new bytes", name);
            errCount++;
        end
        for (int i = 0; i < ChannelCount; i++) begin
            checkLight($sformatf("%s channelLight[%0d]", name, i), golden[base+i],
                       channelLight[i]);
        end
        checkLight({name, " averageLight"}, golden[base+ChannelCount], averageLight);
        checkIndex({name, " brightest"}, chanIdxT'(golden[base+ChannelCount+1]), brightest);
        reportTest(name, errBefore);
    endtask

    // Chip select length and sampleValid spacing and width on falling clk
    always @(negedge clk) begin
        if (!rst_n) begin
            cycle     = 0;
            csPrev    = '1;
            svPrev    = 1'b0;
            svLastAt  = -1;
            csPeriods = 0;
            svGaps    = 0;
        end else begin
            cycle++;
            for (int i = 0; i < ChannelCount; i++) begin
                if (csPrev[i] && !cs[i]) begin
                    csFallAt[i] = cycle;
                end else if (!csPrev[i] && cs[i]) begin
                    checkCycles($sformatf("cs[%0d] low time", i), CsLowCycles,
                                cycle - csFallAt[i]);
                    csPeriods++;
                end
            end
            if (sampleValid && !svPrev) begin
                if (svLastAt >= 0) begin
                    checkCycles("sampleValid spacing", FrameCycles, cycle - svLastAt);
                    svGaps++;
                end
                svLastAt = cycle;
            end else if (!sampleValid && svPrev) begin
                checkCycles("sampleValid width", 1, cycle - svLastAt);
            end
            csPrev = cs;
            svPrev = sampleValid;
        end
    end

    initial begin
        int errBefore;

        rst_n = 1'b0;
        for (int i = 0; i < ChannelCount; i++) begin
            sensorByte[i] <= '0;
        end
        $readmemh("sim/alsGolden.mem", golden);
        if ($isunknown(golden[TestCount*GoldenCols-1])) begin
            $display("Golden file sim/alsGolden.mem is missing or has too few entries");
            errCount++;
        end

        errBefore = errCount;
        repeat (2) @(negedge clk);
        checkIdle("during reset");
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checkIdle("after reset");
        reportTest("reset", errBefore);

        for (int t = 0; t < TestCount; t++) begin
            runFrame(t);
        end

        repeat (2) @(negedge clk);
        errBefore = errCount;
        errCount  = errCount + timingErrs;
        if (csPeriods < (TestCount - 1) * ChannelCount || svGaps != TestCount - 1) begin
            $display("Timing monitor saw too few frames: %0d cs-low periods, %0d gaps",
                     csPeriods, svGaps);
            errCount++;
        end
        reportTest("frame timing", errBefore);

        $display("tests passed %0d, failed %0d, errors %0d", testPasses, testFails, errCount);
        if (errCount == 0 && testFails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/alsGolden.mem
// Columns in hex: ch0 ch1 ch2 ch3 average brightest
// Average is the byte sum divided by 4, truncated; on a tie the lowest channel wins
00 00 00 00 00 00
ff ff ff ff ff 00
10 20 30 40 28 03
80 80 80 80 80 00
01 02 03 04 02 03
40 c0 c0 20 78 01
ff 00 00 00 3f 00
00 00 00 ff 3f 03
12 34 56 78 45 03
9a 05 9a 9a 74 00
03 07 0b 0e 08 03
55 aa 7f aa 8a 01

// File: sim.f
rtl/alsPkg.sv
rtl/sckGen.sv
rtl/alsReader.sv
rtl/lightAggregator.sv
rtl/alsArray.sv
sim/alsSensorModel.sv
sim/alsArrayTb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = alsArrayTb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
